// ==== common/uarch_pkg.sv ====
`default_nettype none

package uarch_pkg;

	// machine word and word-granular address
	typedef logic [31:0] word;
	typedef logic [29:0] ptr;

	// one access on the memory bus or the data port
	typedef struct packed {
		ptr   addr;
		logic write;
		word  data;
	} mem_req_t;

	// prefetch queue holds 2**PREFETCH_ORDER words
	localparam int unsigned PREFETCH_ORDER = 2;
	localparam int unsigned PREFETCH_DEPTH = 1 << PREFETCH_ORDER;

	// first fetch after reset
	localparam ptr RESET_VECTOR = 30'd0;

	// queue pointers and occupancy, one bit wider than the index
	typedef logic [PREFETCH_ORDER:0] qcount;

	// instruction and the pc it came from
	typedef struct packed {
		word insn;
		ptr  pc;
	} fetch_entry_t;

endpackage

`default_nettype wire

// ==== core/core_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_fetch
(
	input  logic           clk,
	input  logic           rst_n,

	input  logic           stall,
	input  logic           branch,
	input  uarch_pkg::ptr  branch_target,

	output logic           fetch,
	output uarch_pkg::ptr  addr,
	input  logic           fetched,
	input  uarch_pkg::word fetch_data,

	output logic           insn_valid,
	output uarch_pkg::word insn,
	output uarch_pkg::ptr  insn_pc
);

	import uarch_pkg::*;

	fetch_entry_t queue[PREFETCH_DEPTH];

	// extra msb tells full from empty
	qcount rd_ptr;
	qcount wr_ptr;

	// queued entries plus the fetch in flight, unless it is stale
	qcount count;

	ptr pc_next;
	logic busy;
	logic discard;

	logic consume;
	logic issue;
	logic store;
	logic room;

	fetch_entry_t head;

	assign head = queue[rd_ptr[PREFETCH_ORDER-1:0]];

	assign insn_valid = rd_ptr != wr_ptr;
	assign insn = head.insn;
	assign insn_pc = head.pc;

	assign consume = insn_valid && !stall;

	// a slot must be free before the word is even requested
	assign room = count != qcount'(PREFETCH_DEPTH);

	// a new fetch may go out on the ready of the last one
	assign issue = !branch && (!busy || fetched) && room;

	// replies that belong to a flushed stream never reach the queue
	assign store = fetched && !discard && !branch;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			pc_next <= RESET_VECTOR;
			busy <= 1'b0;
			discard <= 1'b0;
			fetch <= 1'b0;
		end else begin
			fetch <= issue;

			if (branch) begin
				rd_ptr <= '0;
				wr_ptr <= '0;
				count <= '0;
				pc_next <= branch_target;

				// a reply still on its way is waited for and dropped
				busy <= busy && !fetched;
				discard <= busy && !fetched;
			end else begin
				if (store)
					wr_ptr <= wr_ptr + 1'b1;

				if (consume)
					rd_ptr <= rd_ptr + 1'b1;

				if (fetched)
					discard <= 1'b0;

				if (issue)
					pc_next <= pc_next + 1'b1;

				count <= count + qcount'(issue) - qcount'(consume);
				busy <= issue || (busy && !fetched);
			end
		end
	end

	// address stays put for the whole transaction
	always_ff @(posedge clk) begin
		if (issue)
			addr <= pc_next;
	end

	always_ff @(posedge clk) begin
		if (store) begin
			queue[wr_ptr[PREFETCH_ORDER-1:0]] <= '{
				insn: fetch_data,
				pc:   addr
			};
		end
	end

endmodule

`default_nettype wire

// ==== core/core_mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_mmu
(
	input  logic                clk,
	input  logic                rst_n,

	input  logic                insn_start,
	input  uarch_pkg::ptr       insn_addr,
	output logic                insn_ready,
	output uarch_pkg::word      insn_data_rd,

	input  logic                data_start,
	input  uarch_pkg::mem_req_t data_req,
	output logic                data_ready,
	output uarch_pkg::word      data_rd,

	output logic                bus_start,
	output uarch_pkg::mem_req_t bus_req,
	input  logic                bus_ready,
	input  uarch_pkg::word      bus_rd
);

	import uarch_pkg::*;

	typedef enum logic [1:0] {
		OWNER_NONE,
		OWNER_INSN,
		OWNER_DATA
	} owner_t;

	// port whose transaction is on the bus
	owner_t owner;
	owner_t next_owner;

	// requests that could not go out yet
	logic insn_hold;
	logic data_hold;
	ptr insn_addr_hold;
	mem_req_t data_req_hold;

	logic bus_free;
	logic want_insn;
	logic want_data;
	logic grant;

	mem_req_t insn_req;
	mem_req_t data_next;
	mem_req_t grant_req;

	assign bus_free = owner == OWNER_NONE || bus_ready;

	assign want_data = data_hold || data_start;
	assign want_insn = insn_hold || insn_start;

	assign data_next = data_hold ? data_req_hold : data_req;

	// instruction fetches are plain reads
	always_comb begin
		insn_req = '0;
		insn_req.addr = insn_hold ? insn_addr_hold : insn_addr;
		insn_req.write = 1'b0;
	end

	// data first, fetch only when data has nothing
	always_comb begin
		next_owner = OWNER_NONE;
		grant_req = insn_req;

		if (want_data) begin
			next_owner = OWNER_DATA;
			grant_req = data_next;
		end else if (want_insn) begin
			next_owner = OWNER_INSN;
		end
	end

	assign grant = bus_free && next_owner != OWNER_NONE;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			owner <= OWNER_NONE;
			bus_start <= 1'b0;
			insn_hold <= 1'b0;
			data_hold <= 1'b0;
		end else begin
			bus_start <= grant;

			if (bus_free)
				owner <= next_owner;

			// losing port keeps its request for the next free slot
			if (bus_free && next_owner == OWNER_DATA)
				data_hold <= 1'b0;
			else if (data_start)
				data_hold <= 1'b1;

			if (bus_free && next_owner == OWNER_INSN)
				insn_hold <= 1'b0;
			else if (insn_start)
				insn_hold <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (data_start)
			data_req_hold <= data_req;

		if (insn_start)
			insn_addr_hold <= insn_addr;

		if (grant)
			bus_req <= grant_req;
	end

	// completion goes back to whoever owns the transaction
	assign insn_ready = bus_ready && owner == OWNER_INSN;
	assign data_ready = bus_ready && owner == OWNER_DATA;

	assign insn_data_rd = bus_rd;
	assign data_rd = bus_rd;

endmodule

`default_nettype wire

// ==== rtl/core_memsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_memsys
(
	input  logic                clk,
	input  logic                rst_n,

	// instruction stream towards decode
	input  logic                stall,
	input  logic                branch,
	input  uarch_pkg::ptr       branch_target,
	output logic                insn_valid,
	output uarch_pkg::word      insn,
	output uarch_pkg::ptr       insn_pc,

	// load/store port of the execute stage
	input  logic                data_start,
	input  uarch_pkg::mem_req_t data_req,
	output logic                data_ready,
	output uarch_pkg::word      data_rd,

	// external memory bus
	output logic                bus_start,
	output uarch_pkg::mem_req_t bus_req,
	input  logic                bus_ready,
	input  uarch_pkg::word      bus_rd
);

	import uarch_pkg::*;

	ptr fetch_addr;
	word fetch_data;
	logic fetch_start;
	logic fetch_ready;

	core_fetch fetch
	(
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.branch(branch),
		.branch_target(branch_target),
		.fetch(fetch_start),
		.addr(fetch_addr),
		.fetched(fetch_ready),
		.fetch_data(fetch_data),
		.insn_valid(insn_valid),
		.insn(insn),
		.insn_pc(insn_pc)
	);

	core_mmu mmu
	(
		.clk(clk),
		.rst_n(rst_n),
		.insn_start(fetch_start),
		.insn_addr(fetch_addr),
		.insn_ready(fetch_ready),
		.insn_data_rd(fetch_data),
		.data_start(data_start),
		.data_req(data_req),
		.data_ready(data_ready),
		.data_rd(data_rd),
		.bus_start(bus_start),
		.bus_req(bus_req),
		.bus_ready(bus_ready),
		.bus_rd(bus_rd)
	);

endmodule

`default_nettype wire

// ==== test/bus_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_mem
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  uarch_pkg::mem_req_t req,
	output logic                ready,
	output uarch_pkg::word      rd
);

	import uarch_pkg::*;

	localparam int MEM_WORDS = 1024;

	word mem[MEM_WORDS];
	mem_req_t req_q;
	logic busy;
	logic [2:0] wait_q;
	integer seed;

	// same sequence as the shadow copy in the testbench
	initial begin
		seed = 63;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = $random(seed);
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready <= 1'b0;
			busy <= 1'b0;
			wait_q <= 3'd0;
			rd <= '0;
		end else begin
			ready <= 1'b0;
			if (start) begin
				req_q <= req;
				busy <= 1'b1;
				// 1 to 4 cycles until ready
				wait_q <= 3'(1 + ($random(seed) & 3));
			end else if (busy) begin
				if (wait_q == 3'd1) begin
					ready <= 1'b1;
					busy <= 1'b0;
					if (req_q.write)
						mem[req_q.addr[9:0]] <= req_q.data;
					else
						rd <= mem[req_q.addr[9:0]];
				end else begin
					wait_q <= wait_q - 3'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_core_memsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core_memsys;

	import uarch_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int RUN_CYCLES = 16000;
	// run length plus a quarter for the drain at the end
	localparam int WATCHDOG_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;
	localparam int MEM_WORDS = 1024;
	localparam int DATA_TIMEOUT = 16;

	logic clk;
	logic rst_n;
	logic stall;
	logic branch;
	ptr branch_target;
	logic insn_valid;
	word insn;
	ptr insn_pc;
	logic data_start;
	mem_req_t data_req;
	logic data_ready;
	word data_rd;
	logic bus_start;
	mem_req_t bus_req;
	logic bus_ready;
	word bus_rd;

	word shadow[MEM_WORDS];
	integer seed;
	int cycle;

	logic consumed;
	ptr expected_pc;
	mem_req_t op_q;
	logic data_busy;
	int data_wait;
	word expect_insn;
	word expect_rd;
	ptr last_store;
	logic bus_open;
	logic bus_free;

	int n_consumed;
	int n_branches;
	int n_loads;
	int n_stores;

	core_memsys core_memsys_i (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.branch(branch),
		.branch_target(branch_target),
		.insn_valid(insn_valid),
		.insn(insn),
		.insn_pc(insn_pc),
		.data_start(data_start),
		.data_req(data_req),
		.data_ready(data_ready),
		.data_rd(data_rd),
		.bus_start(bus_start),
		.bus_req(bus_req),
		.bus_ready(bus_ready),
		.bus_rd(bus_rd)
	);

	bus_mem memory (
		.clk(clk),
		.rst_n(rst_n),
		.start(bus_start),
		.req(bus_req),
		.ready(bus_ready),
		.rd(bus_rd)
	);

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		$display("FAIL %s: got %0h expected %0h", name, got, want);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_failure("timeout, the run did not finish in time");
	end

	assign consumed = insn_valid && !stall;
	assign expect_insn = shadow[insn_pc[9:0]];
	assign expect_rd = shadow[op_q.addr[9:0]];

	// no transaction open or starting, or the open one ends now
	assign bus_free = bus_ready || !(bus_open || bus_start);

	// expected pc of the next consumed insn, open data access, shadow writes
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			expected_pc <= RESET_VECTOR;
			data_busy <= 1'b0;
			data_wait <= 0;
			bus_open <= 1'b0;
			n_consumed <= 0;
			n_branches <= 0;
			n_loads <= 0;
			n_stores <= 0;
		end else begin
			if (branch) begin
				expected_pc <= branch_target;
				n_branches <= n_branches + 1;
			end else if (consumed) begin
				expected_pc <= expected_pc + 1'b1;
			end
			if (consumed)
				n_consumed <= n_consumed + 1;
			if (bus_start)
				bus_open <= 1'b1;
			else if (bus_ready)
				bus_open <= 1'b0;
			if (data_start) begin
				data_busy <= 1'b1;
				data_wait <= 0;
				op_q <= data_req;
			end else if (data_ready) begin
				data_busy <= 1'b0;
				if (op_q.write) begin
					shadow[op_q.addr[9:0]] <= op_q.data;
					n_stores <= n_stores + 1;
				end else begin
					n_loads <= n_loads + 1;
				end
			end else if (data_busy) begin
				data_wait <= data_wait + 1;
			end
		end
	end

	assert property (@(posedge clk) !rst_n |-> !bus_start && !insn_valid && !data_ready)
		else report_failure("bus_start, insn_valid or data_ready high during reset");

	assert property (@(posedge clk) disable iff (!rst_n)
		consumed |-> insn == expect_insn)
		else report_mismatch("insn", $sampled(insn), $sampled(expect_insn));

	assert property (@(posedge clk) disable iff (!rst_n)
		consumed |-> insn_pc == expected_pc)
		else report_mismatch("insn_pc", 32'($sampled(insn_pc)), 32'($sampled(expected_pc)));

	// head of the queue holds while stalled
	assert property (@(posedge clk) disable iff (!rst_n)
		insn_valid && stall && !branch |=>
			insn_valid && insn == $past(insn) && insn_pc == $past(insn_pc))
		else report_failure("the stalled instruction changed or went away");

	assert property (@(posedge clk) disable iff (!rst_n)
		data_ready && !op_q.write |-> data_rd == expect_rd)
		else report_mismatch("data_rd", $sampled(data_rd), $sampled(expect_rd));

	assert property (@(posedge clk) disable iff (!rst_n)
		data_ready |-> data_busy)
		else report_failure("data_ready came without an open data access");

	assert property (@(posedge clk) disable iff (!rst_n)
		data_busy |-> data_wait < DATA_TIMEOUT)
		else report_failure("a data access got no data_ready within 16 cycles");

	// one bus transaction at a time
	assert property (@(posedge clk) disable iff (!rst_n)
		bus_start |-> !bus_open)
		else report_failure("bus_start while a bus transaction was still open");

	// data wins a free bus and goes out in the next cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		data_start && bus_free |=> bus_start)
		else report_failure("a data request did not reach the free bus one cycle later");

	assert property (@(posedge clk) disable iff (!rst_n)
		data_start && bus_free |=> bus_req == op_q)
		else report_mismatch("bus_req", 64'($sampled(bus_req)), 64'($sampled(op_q)));

	// fetches only read, so every bus write is the open data store
	assert property (@(posedge clk) disable iff (!rst_n)
		bus_start && bus_req.write |-> data_busy && bus_req == op_q)
		else report_failure("a bus write went out that the data port did not ask for");

	task automatic drive_stimulus(input int now, input logic allow_data);
		logic heavy;
		heavy = (now % 256) < 96;
		branch = 1'b0;
		data_start = 1'b0;
		// flush prefetched copies of the old word and refetch the stored one
		if (data_ready && op_q.write) begin
			branch = 1'b1;
			branch_target = op_q.addr;
		end else if (($random(seed) & 63) == 0) begin
			branch = 1'b1;
			branch_target = ptr'($random(seed) & (MEM_WORDS - 1));
		end
		if (heavy)
			stall = branch || (($random(seed) & 7) != 0);
		else
			stall = branch || (($random(seed) & 3) == 0);
		if (allow_data && !data_busy && ($random(seed) & 15) == 0) begin
			data_start = 1'b1;
			data_req.write = 1'($random(seed));
			data_req.data = $random(seed);
			if (($random(seed) & 1) != 0)
				data_req.addr = last_store;
			else
				data_req.addr = ptr'($random(seed) & (MEM_WORDS - 1));
			if (data_req.write)
				last_store = data_req.addr;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		stall = 1'b0;
		branch = 1'b0;
		branch_target = '0;
		data_start = 1'b0;
		data_req = '0;
		last_store = '0;
		seed = 63;
		for (int i = 0; i < MEM_WORDS; i++)
			shadow[i] = $random(seed);

		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;

		for (cycle = 0; cycle < RUN_CYCLES; cycle++) begin
			@(posedge clk);
			#2;
			drive_stimulus(cycle, 1'b1);
		end

		// no new data accesses, but stores still get their flush
		while (data_busy || data_start) begin
			@(posedge clk);
			#2;
			drive_stimulus(cycle, 1'b0);
		end

		if (n_consumed == 0 || n_branches == 0 || n_loads == 0 || n_stores == 0) begin
			report_failure("the stimulus did not reach every check");
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/uarch_pkg.sv
core/core_fetch.sv
core/core_mmu.sv
rtl/core_memsys.sv
test/bus_mem.sv
test/tb_core_memsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILE_LIST ?= vlog.f
TB_TOP ?= tb_core_memsys
RTL_TOP ?= core_memsys
OBJ_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --timing --assert
LINT_FLAGS ?= -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILE_LIST) \
		--top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -Mdir $(OBJ_DIR) \
		-f $(FILE_LIST) --top-module $(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
